//--- src/csi2_rx_cfg.svh
`ifndef CSI2_RX_CFG_SVH
`define CSI2_RX_CFG_SVH

// data type codes.
// the upper two bits of the data id carry the virtual channel and are not compared.
`define CSI2_DT_FS     8'h00
`define CSI2_DT_FE     8'h01
`define CSI2_DT_RAW10  8'h2B

// one RAW10 pixel.
`define CSI2_PX_W      10

// four pixels packed into five bytes.
`define CSI2_GROUP_W   40

// packet footer length in bytes.
`define CSI2_CRC_BYTES 2

`endif

//--- src/csi2_rx_pkg.sv
`include "csi2_rx_cfg.svh"

package csi2_rx_pkg;

// word leaving the header ECC stage.
typedef struct packed {
  logic [31 : 0] data;
  logic          is_hdr;
} csi2_word_t;

// framed packet word.
// strb has one bit per valid payload byte, byte 0 in bit 0.
typedef struct packed {
  logic [31 : 0] data;
  logic [3 : 0]  strb;
  logic          sop;
  logic          last;
} csi2_pkt_word_t;

// five RAW10 bytes, the fifth one holds the low bits of all four pixels.
typedef struct packed {
  logic [`CSI2_GROUP_W - 1 : 0] data;
  logic                         sol;
  logic                         eol;
} csi2_group_t;

// four pixels per beat with pixel 0 in the low bits.
typedef struct packed {
  logic [3 : 0][`CSI2_PX_W - 1 : 0] px;
  logic                             sof;
  logic                             sol;
  logic                             eol;
} csi2_video_t;

endpackage

//--- src/csi2_hdr_ecc_dec.sv
`timescale 1ns/100ps

module csi2_hdr_ecc_dec import csi2_rx_pkg::*;
(
  input                rx_clk,
  input                rst_n_i,
  input                word_valid_i,
  input        [31 : 0] word_i,
  input                hdr_wait_i,
  output logic         word_valid_o,
  output csi2_word_t   word_o,
  output logic         hdr_corrected_o,
  output logic         hdr_error_o
);

// parity column of each header data bit, P5 in the msb.
localparam logic [5 : 0] DATA_COL [24] = '{
  6'h07, 6'h0b, 6'h0d, 6'h0e, 6'h13, 6'h15, 6'h16, 6'h19,
  6'h1a, 6'h1c, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2a, 6'h2c,
  6'h31, 6'h32, 6'h34, 6'h38, 6'h1f, 6'h2f, 6'h37, 6'h3b
};

logic          is_hdr;
logic [5 : 0]  parity;
logic [5 : 0]  syndrome;
logic [29 : 0] fix_mask;
logic          fix_corr;
logic          fix_err;
logic          corr_d1;
logic          err_d1;

assign is_hdr = word_valid_i && hdr_wait_i;

always_comb
  begin
    parity = '0;
    for( int i = 0; i < 24; i++ )
      if( word_i[i] )
        parity = parity ^ DATA_COL[i];
    syndrome = parity ^ word_i[29 : 24];
    fix_mask = '0;
    for( int i = 0; i < 24; i++ )
      if( syndrome == DATA_COL[i] )
        fix_mask[i] = 1'b1;
    // a syndrome with a single bit set points into the ECC field itself.
    for( int k = 0; k < 6; k++ )
      if( syndrome == 6'( 1 << k ) )
        fix_mask[24 + k] = 1'b1;
  end

assign fix_corr = is_hdr && ( fix_mask != '0 );
assign fix_err  = is_hdr && ( syndrome != '0 ) && ( fix_mask == '0 );

always_ff @( posedge rx_clk )
  begin
    if( !rst_n_i )
      begin
        word_valid_o    <= 1'b0;
        corr_d1         <= 1'b0;
        err_d1          <= 1'b0;
        hdr_corrected_o <= 1'b0;
        hdr_error_o     <= 1'b0;
      end
    else
      begin
        word_valid_o    <= word_valid_i;
        corr_d1         <= fix_corr;
        err_d1          <= fix_err;
        hdr_corrected_o <= corr_d1;
        hdr_error_o     <= err_d1;
      end
  end

// uncorrectable headers go out as received.
always_ff @( posedge rx_clk )
  begin
    word_o.data   <= is_hdr ? ( word_i ^ { 2'b00, fix_mask } ) : word_i;
    word_o.is_hdr <= is_hdr;
  end

endmodule

//--- src/csi2_pkt_framer.sv
`timescale 1ns/100ps

`include "csi2_rx_cfg.svh"

module csi2_pkt_framer import csi2_rx_pkg::*;
(
  input                  rx_clk,
  input                  rst_n_i,
  input                  hs_active_i,
  input                  word_valid_i,
  input  csi2_word_t     word_i,
  input                  hdr_error_i,
  output logic           hdr_wait_o,
  output logic           pkt_valid_o,
  output csi2_pkt_word_t pkt_o
);

// data types from 0x10 up are long packets.
localparam logic [5 : 0] DT_LONG_MIN = 6'h10;
localparam int           CRC_BYTES   = `CSI2_CRC_BYTES;

typedef enum logic [1 : 0] {
  WAIT_HDR_S,
  PAYLOAD_S,
  DISCARD_S
} state_t;

state_t         state;
state_t         state_next;
logic           hs_d1;
logic [16 : 0]  byte_cnt;
logic [16 : 0]  byte_cnt_next;
logic [16 : 0]  pay_left;
logic           is_long;
logic           emit;
logic           pkt_valid;
csi2_pkt_word_t pkt_next;

assign is_long  = ( word_i.data[5 : 0] >= DT_LONG_MIN );
assign pay_left = byte_cnt - 17'( CRC_BYTES );

always_comb
  begin
    state_next    = state;
    byte_cnt_next = byte_cnt;
    emit          = 1'b0;
    pkt_next      = '0;
    pkt_next.data = word_i.data;
    // hs_d1 lines the burst level up with the words coming out of the ECC stage.
    if( !hs_d1 )
      state_next = WAIT_HDR_S;
    else if( hdr_error_i )
      state_next = DISCARD_S;
    else if( word_valid_i )
      case( state )
        WAIT_HDR_S:
          if( word_i.is_hdr )
            begin
              emit          = 1'b1;
              pkt_next.sop  = 1'b1;
              pkt_next.last = !is_long || ( word_i.data[23 : 8] == '0 );
              if( is_long )
                begin
                  state_next    = PAYLOAD_S;
                  byte_cnt_next = { 1'b0, word_i.data[23 : 8] } + 17'( CRC_BYTES );
                end
            end
        PAYLOAD_S:
          begin
            // words holding only CRC bytes are swallowed.
            emit          = ( byte_cnt > 17'( CRC_BYTES ) );
            pkt_next.strb = ( pay_left >= 17'd4 ) ? 4'hf :
                            ( pay_left == 17'd3 ) ? 4'h7 :
                            ( pay_left == 17'd2 ) ? 4'h3 : 4'h1;
            pkt_next.last = ( pay_left <= 17'd4 );
            byte_cnt_next = byte_cnt - 17'd4;
            if( byte_cnt <= 17'd4 )
              state_next = WAIT_HDR_S;
          end
        default:
          state_next = state;
      endcase
  end

// the ECC stage classifies its next input with this level.
assign hdr_wait_o = ( state_next == WAIT_HDR_S );

always_ff @( posedge rx_clk )
  begin
    if( !rst_n_i )
      begin
        state     <= WAIT_HDR_S;
        hs_d1     <= 1'b0;
        byte_cnt  <= '0;
        pkt_valid <= 1'b0;
      end
    else
      begin
        state     <= state_next;
        hs_d1     <= hs_active_i;
        byte_cnt  <= byte_cnt_next;
        pkt_valid <= emit;
      end
  end

always_ff @( posedge rx_clk )
  pkt_o <= pkt_next;

// the ECC error flag trails the header by one cycle, so a bad header
// already sitting in the output register is withdrawn here.
assign pkt_valid_o = pkt_valid && !hdr_error_i;

endmodule

//--- src/csi2_payload_extract.sv
`timescale 1ns/100ps

`include "csi2_rx_cfg.svh"

module csi2_payload_extract import csi2_rx_pkg::*;
(
  input                  rx_clk,
  input                  rst_n_i,
  input                  pkt_valid_i,
  input  csi2_pkt_word_t pkt_i,
  output logic           pay_valid_o,
  output csi2_pkt_word_t pay_o,
  output logic           frame_start_o,
  output logic           frame_end_o
);

localparam logic [7 : 0] DT_FS    = `CSI2_DT_FS;
localparam logic [7 : 0] DT_FE    = `CSI2_DT_FE;
localparam logic [7 : 0] DT_RAW10 = `CSI2_DT_RAW10;

logic [5 : 0] data_type;
logic         line_start;
logic         is_raw10;

assign is_raw10 = ( data_type == DT_RAW10[5 : 0] );

always_ff @( posedge rx_clk )
  begin
    if( !rst_n_i )
      begin
        data_type     <= '0;
        line_start    <= 1'b0;
        pay_valid_o   <= 1'b0;
        frame_start_o <= 1'b0;
        frame_end_o   <= 1'b0;
      end
    else
      begin
        pay_valid_o   <= 1'b0;
        frame_start_o <= 1'b0;
        frame_end_o   <= 1'b0;
        if( pkt_valid_i )
          begin
            if( pkt_i.sop )
              begin
                data_type     <= pkt_i.data[5 : 0];
                line_start    <= 1'b1;
                frame_start_o <= ( pkt_i.data[5 : 0] == DT_FS[5 : 0] );
                frame_end_o   <= ( pkt_i.data[5 : 0] == DT_FE[5 : 0] );
              end
            else if( is_raw10 )
              begin
                pay_valid_o <= 1'b1;
                line_start  <= 1'b0;
              end
          end
      end
  end

// sop now marks the first payload word of a line.
always_ff @( posedge rx_clk )
  begin
    pay_o     <= pkt_i;
    pay_o.sop <= line_start;
  end

endmodule

//--- src/csi2_raw10_gearbox.sv
`timescale 1ns/100ps

`include "csi2_rx_cfg.svh"

module csi2_raw10_gearbox import csi2_rx_pkg::*;
(
  input                  rx_clk,
  input                  rst_n_i,
  input                  pay_valid_i,
  input  csi2_pkt_word_t pay_i,
  output logic           grp_valid_o,
  output csi2_group_t    grp_o
);

localparam int GW = `CSI2_GROUP_W;

logic [2 : 0]  phase;
logic [2 : 0]  phase_cur;
logic [2 : 0]  phase_next;
logic [5 : 0]  held_bits;
logic [31 : 0] word;
logic [63 : 0] residue;
logic [63 : 0] merged;
logic          emit;
logic          sol_pend;

always_comb
  begin
    for( int b = 0; b < 4; b++ )
      word[8 * b +: 8] = pay_i.strb[b] ? pay_i.data[8 * b +: 8] : 8'h00;
    // a new line always starts from an empty residue.
    phase_cur = pay_i.sop ? 3'd0 : phase;
    case( phase_cur )
      3'd1:    held_bits = 6'd32;
      3'd2:    held_bits = 6'd24;
      3'd3:    held_bits = 6'd16;
      3'd4:    held_bits = 6'd8;
      default: held_bits = 6'd0;
    endcase
    merged = ( phase_cur == 3'd0 ) ? 64'h0 : residue;
    merged = merged | ( { 32'h0, word } << held_bits );
    emit   = ( phase_cur != 3'd0 );
    if( pay_i.last || ( phase_cur == 3'd4 ) )
      phase_next = 3'd0;
    else
      phase_next = phase_cur + 3'd1;
  end

always_ff @( posedge rx_clk )
  begin
    if( !rst_n_i )
      begin
        phase       <= 3'd0;
        sol_pend    <= 1'b0;
        grp_valid_o <= 1'b0;
      end
    else
      begin
        grp_valid_o <= pay_valid_i && emit;
        if( pay_valid_i )
          begin
            phase <= phase_next;
            if( pay_i.sop )
              sol_pend <= 1'b1;
            else if( emit )
              sol_pend <= 1'b0;
          end
      end
  end

always_ff @( posedge rx_clk )
  begin
    if( pay_valid_i )
      residue <= emit ? ( merged >> GW ) : merged;
    grp_o.data <= merged[GW - 1 : 0];
    grp_o.sol  <= sol_pend;
    grp_o.eol  <= pay_i.last;
  end

endmodule

//--- src/csi2_px_unpacker.sv
`timescale 1ns/100ps

`include "csi2_rx_cfg.svh"

module csi2_px_unpacker import csi2_rx_pkg::*;
(
  input               rx_clk,
  input               rst_n_i,
  input               frame_start_i,
  input               grp_valid_i,
  input  csi2_group_t grp_i,
  output logic        video_valid_o,
  output csi2_video_t video_o
);

// upper part of each pixel sits in its own byte.
localparam int MSB_W    = `CSI2_PX_W - 2;
localparam int LSB_BASE = 4 * MSB_W;

logic        sof_pend;
csi2_video_t video;

always_comb
  begin
    for( int i = 0; i < 4; i++ )
      video.px[i] = { grp_i.data[MSB_W * i +: MSB_W], grp_i.data[LSB_BASE + 2 * i +: 2] };
    video.sof = sof_pend;
    video.sol = grp_i.sol;
    video.eol = grp_i.eol;
  end

always_ff @( posedge rx_clk )
  begin
    if( !rst_n_i )
      begin
        sof_pend      <= 1'b0;
        video_valid_o <= 1'b0;
      end
    else
      begin
        video_valid_o <= grp_valid_i;
        // armed by frame start, spent on the first group after it.
        if( frame_start_i )
          sof_pend <= 1'b1;
        else if( grp_valid_i )
          sof_pend <= 1'b0;
      end
  end

always_ff @( posedge rx_clk )
  video_o <= video;

endmodule

//--- src/csi2_rx.sv
`timescale 1ns/100ps

module csi2_rx import csi2_rx_pkg::*;
(
  input                rx_clk,
  input                rst_n_i,
  input                hs_active_i,
  input                word_valid_i,
  input        [31 : 0] word_i,
  output logic         video_valid_o,
  output csi2_video_t  video_o,
  output logic         frame_end_o,
  output logic         hdr_corrected_o,
  output logic         hdr_error_o
);

logic           ecc_valid;
csi2_word_t     ecc_word;
logic           hdr_wait;
logic           pkt_valid;
csi2_pkt_word_t pkt_word;
logic           pay_valid;
csi2_pkt_word_t pay_word;
logic           frame_start;
logic           grp_valid;
csi2_group_t    grp;

csi2_hdr_ecc_dec hdr_ecc (
  .rx_clk          ( rx_clk          ),
  .rst_n_i         ( rst_n_i         ),
  .word_valid_i    ( word_valid_i    ),
  .word_i          ( word_i          ),
  .hdr_wait_i      ( hdr_wait        ),
  .word_valid_o    ( ecc_valid       ),
  .word_o          ( ecc_word        ),
  .hdr_corrected_o ( hdr_corrected_o ),
  .hdr_error_o     ( hdr_error_o     )
);

csi2_pkt_framer framer (
  .rx_clk       ( rx_clk      ),
  .rst_n_i      ( rst_n_i     ),
  .hs_active_i  ( hs_active_i ),
  .word_valid_i ( ecc_valid   ),
  .word_i       ( ecc_word    ),
  .hdr_error_i  ( hdr_error_o ),
  .hdr_wait_o   ( hdr_wait    ),
  .pkt_valid_o  ( pkt_valid   ),
  .pkt_o        ( pkt_word    )
);

csi2_payload_extract extract (
  .rx_clk        ( rx_clk      ),
  .rst_n_i       ( rst_n_i     ),
  .pkt_valid_i   ( pkt_valid   ),
  .pkt_i         ( pkt_word    ),
  .pay_valid_o   ( pay_valid   ),
  .pay_o         ( pay_word    ),
  .frame_start_o ( frame_start ),
  .frame_end_o   ( frame_end_o )
);

csi2_raw10_gearbox gbx (
  .rx_clk      ( rx_clk    ),
  .rst_n_i     ( rst_n_i   ),
  .pay_valid_i ( pay_valid ),
  .pay_i       ( pay_word  ),
  .grp_valid_o ( grp_valid ),
  .grp_o       ( grp       )
);

csi2_px_unpacker unpacker (
  .rx_clk        ( rx_clk        ),
  .rst_n_i       ( rst_n_i       ),
  .frame_start_i ( frame_start   ),
  .grp_valid_i   ( grp_valid     ),
  .grp_i         ( grp           ),
  .video_valid_o ( video_valid_o ),
  .video_o       ( video_o       )
);

endmodule

//--- verification/csi2_rx_tb.sv
`timescale 1ns/100ps

`include "csi2_rx_cfg.svh"

module csi2_rx_tb import csi2_rx_pkg::*;
();

localparam logic [7 : 0] DT_FS    = `CSI2_DT_FS;
localparam logic [7 : 0] DT_FE    = `CSI2_DT_FE;
localparam logic [7 : 0] DT_RAW10 = `CSI2_DT_RAW10;

// data bits feeding each ECC parity bit, P0 first.
localparam logic [23 : 0] ECC_ROW [6] = '{
  24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00
};

typedef struct {
  csi2_video_t video;
  int          due;
} exp_t;

logic          rx_clk;
logic          rst_n_i;
logic          hs_active_i;
logic          word_valid_i;
logic [31 : 0] word_i;
logic          video_valid_o;
csi2_video_t   video_o;
logic          frame_end_o;
logic          hdr_corrected_o;
logic          hdr_error_o;

int           cyc = 0;
int           words_sent = 0;
int           error_cnt = 0;
int           errors_before = 0;
int           tests_run = 0;
int           fe_due = -1;
int           corr_due = -1;
int           err_due = -1;
bit           sof_armed;
logic [7 : 0] line_bytes [$];
exp_t         exp_q [$];
exp_t         exp_head;
bit           exp_any;

csi2_rx DUT ( .* );

initial
  rx_clk = 1'b0;

always
  #4 rx_clk = ~rx_clk;

always @( posedge rx_clk )
  cyc <= cyc + 1;

function automatic logic [5 : 0] calc_ecc( input logic [23 : 0] d );
  logic [5 : 0] e;
  for( int p = 0; p < 6; p++ )
    e[p] = ^( d & ECC_ROW[p] );
  return e;
endfunction

function automatic logic [31 : 0] make_header( input logic [7 : 0] id, input logic [15 : 0] wc );
  return { 2'b00, calc_ecc( { wc, id } ), wc, id };
endfunction

// a single-bit syndrome or one that equals a data column can be repaired.
function automatic bit is_correctable( input logic [31 : 0] hdr );
  logic [5 : 0] syn;
  logic [5 : 0] col;
  bit           hit;
  syn = calc_ecc( hdr[23 : 0] ) ^ hdr[29 : 24];
  hit = ( $countones( syn ) == 1 );
  for( int i = 0; i < 24; i++ )
    begin
      for( int p = 0; p < 6; p++ )
        col[p] = ECC_ROW[p][i];
      if( syn == col )
        hit = 1'b1;
    end
  return hit;
endfunction

// two flips outside the data id, so the data type stays RAW10.
function automatic logic [29 : 0] pick_double_flip();
  logic [29 : 0] f;
  int            a;
  int            b;
  do
    begin
      a = $urandom_range( 29, 8 );
      b = $urandom_range( 29, 8 );
      f = ( 30'd1 << a ) | ( 30'd1 << b );
    end
  while( a == b || is_correctable( { 2'b00, f } ) );
  return f;
endfunction

// four pixels from five line bytes, the fifth holding the low bit pairs.
task automatic push_group( input int g, input int due, input bit last_grp );
  exp_t e;
  e.due = due;
  for( int i = 0; i < 4; i++ )
    e.video.px[i] = { line_bytes[5 * g + i], line_bytes[5 * g + 4][2 * i +: 2] };
  e.video.sof = sof_armed;
  e.video.sol = ( g == 0 );
  e.video.eol = last_grp;
  sof_armed = 1'b0;
  exp_q.push_back( e );
endtask

task automatic drive_word( input logic [31 : 0] w, input int gap_pct, output int t );
  if( $urandom_range( 99 ) < gap_pct )
    repeat( $urandom_range( 3, 1 ) )
      begin
        @( posedge rx_clk );
        word_valid_i <= 1'b0;
      end
  @( posedge rx_clk );
  word_valid_i <= 1'b1;
  word_i       <= w;
  t = cyc;
  words_sent++;
endtask

// one packet per burst; long packets end with a crc word.
task automatic send_packet( input logic [7 : 0] id, input int wc, input bit is_long,
                            input logic [29 : 0] flip, input int gap_pct );
  logic [31 : 0] hdr;
  int            t;
  bit            good;
  bit            raw10;
  line_bytes.delete();
  for( int i = 0; i < wc; i++ )
    line_bytes.push_back( 8'( $urandom ) );
  hdr   = make_header( id, is_long ? 16'( wc ) : 16'( $urandom ) ) ^ { 2'b00, flip };
  good  = ( flip == '0 ) || is_correctable( hdr );
  raw10 = is_long && ( id[5 : 0] == DT_RAW10[5 : 0] );
  @( posedge rx_clk );
  hs_active_i <= 1'b1;
  drive_word( hdr, 0, t );
  if( flip != '0 )
    begin
      if( good )
        corr_due = t + 3;
      else
        err_due = t + 3;
    end
  if( !is_long && id[5 : 0] == DT_FE[5 : 0] )
    fe_due = t + 4;
  if( !is_long && id[5 : 0] == DT_FS[5 : 0] )
    sof_armed = 1'b1;
  if( is_long )
    begin
      for( int k = 0; k < wc / 4; k++ )
        begin
          drive_word( { line_bytes[4 * k + 3], line_bytes[4 * k + 2],
                        line_bytes[4 * k + 1], line_bytes[4 * k] }, gap_pct, t );
          if( good && raw10 && ( 4 * ( k + 1 ) ) / 5 > ( 4 * k ) / 5 )
            push_group( ( 4 * ( k + 1 ) ) / 5 - 1, t + 6, k == wc / 4 - 1 );
        end
      // crc in the low half, filler above it.
      drive_word( $urandom, gap_pct, t );
    end
  @( posedge rx_clk );
  word_valid_i <= 1'b0;
  hs_active_i  <= 1'b0;
  repeat( 3 ) @( posedge rx_clk );
endtask

task automatic send_line( input logic [29 : 0] flip, input int gap_pct );
  send_packet( DT_RAW10, 20 * $urandom_range( 8, 1 ), 1'b1, flip, gap_pct );
endtask

task automatic send_frame( input int lines, input int gap_pct );
  send_packet( DT_FS, 0, 1'b0, '0, 0 );
  for( int i = 0; i < lines; i++ )
    send_line( '0, gap_pct );
  send_packet( DT_FE, 0, 1'b0, '0, 0 );
endtask

task automatic finish_test( input string name );
  repeat( 8 ) @( posedge rx_clk );
  while( exp_q.size() != 0 )
    @( posedge rx_clk );
  repeat( 4 ) @( posedge rx_clk );
  if( error_cnt == errors_before )
    $display( "%s: ok", name );
  else
    $display( "%s: %0d errors", name, error_cnt - errors_before );
  tests_run++;
  errors_before = error_cnt;
endtask

// retire the head entry once it is seen or overdue.
always @( posedge rx_clk )
  begin
    if( exp_any && ( video_valid_o || cyc > exp_head.due ) )
      void'( exp_q.pop_front() );
    exp_any <= ( exp_q.size() != 0 );
    if( exp_q.size() != 0 )
      exp_head <= exp_q[0];
  end

a_expected: assert property( @( posedge rx_clk ) disable iff( !rst_n_i )
  video_valid_o |-> exp_any )
  else
    begin
      $display( "unexpected pixel group at cycle %0d", $sampled( cyc ) );
      error_cnt++;
    end

a_pixels: assert property( @( posedge rx_clk ) disable iff( !rst_n_i )
  video_valid_o && exp_any |-> video_o.px == exp_head.video.px )
  else
    begin
      $display( "FAIL video_o.px got %h expected %h", $sampled( video_o.px ),
                $sampled( exp_head.video.px ) );
      error_cnt++;
    end

a_marks: assert property( @( posedge rx_clk ) disable iff( !rst_n_i )
  video_valid_o && exp_any |->
    { video_o.sof, video_o.sol, video_o.eol } ==
    { exp_head.video.sof, exp_head.video.sol, exp_head.video.eol } )
  else
    begin
      $display( "FAIL video_o.{sof,sol,eol} got %h expected %h",
                $sampled( { video_o.sof, video_o.sol, video_o.eol } ),
                $sampled( { exp_head.video.sof, exp_head.video.sol, exp_head.video.eol } ) );
      error_cnt++;
    end

a_latency: assert property( @( posedge rx_clk ) disable iff( !rst_n_i )
  video_valid_o && exp_any |-> cyc == exp_head.due )
  else
    begin
      $display( "pixel group arrived at cycle %0d instead of %0d", $sampled( cyc ),
                $sampled( exp_head.due ) );
      error_cnt++;
    end

a_missing: assert property( @( posedge rx_clk ) disable iff( !rst_n_i )
  exp_any |-> cyc <= exp_head.due )
  else
    begin
      $display( "pixel group due at cycle %0d never arrived", $sampled( exp_head.due ) );
      error_cnt++;
    end

a_frame_end: assert property( @( posedge rx_clk ) disable iff( !rst_n_i )
  frame_end_o == ( cyc == fe_due ) )
  else
    begin
      $display( "FAIL frame_end_o got %h expected %h", $sampled( frame_end_o ),
                $sampled( cyc == fe_due ) );
      error_cnt++;
    end

a_corrected: assert property( @( posedge rx_clk ) disable iff( !rst_n_i )
  hdr_corrected_o == ( cyc == corr_due ) )
  else
    begin
      $display( "FAIL hdr_corrected_o got %h expected %h", $sampled( hdr_corrected_o ),
                $sampled( cyc == corr_due ) );
      error_cnt++;
    end

a_hdr_error: assert property( @( posedge rx_clk ) disable iff( !rst_n_i )
  hdr_error_o == ( cyc == err_due ) )
  else
    begin
      $display( "FAIL hdr_error_o got %h expected %h", $sampled( hdr_error_o ),
                $sampled( cyc == err_due ) );
      error_cnt++;
    end

initial
  begin
    while( cyc < 20 * words_sent + 1000 )
      @( posedge rx_clk );
    $display( "timeout: no progress after %0d cycles", cyc );
    $display( "FAIL: see errors above" );
    $finish;
  end

initial
  begin
    void'( $urandom( 32'hbf37 ) );
    rst_n_i      = 1'b0;
    hs_active_i  = 1'b0;
    word_valid_i = 1'b0;
    word_i       = '0;
    repeat( 8 ) @( posedge rx_clk );
    rst_n_i <= 1'b1;
    repeat( 4 ) @( posedge rx_clk );

    send_frame( 3, 0 );
    finish_test( "test 1 raw10 frame" );

    send_frame( 5, 0 );
    finish_test( "test 2 group latency" );

    send_packet( DT_FS, 0, 1'b0, '0, 0 );
    send_line( 30'd1 << $urandom_range( 29, 0 ), 0 );
    send_line( 30'd1 << $urandom_range( 29, 0 ), 0 );
    send_packet( DT_FE, 0, 1'b0, '0, 0 );
    finish_test( "test 3 single bit header error" );

    send_packet( DT_FS, 0, 1'b0, '0, 0 );
    send_line( pick_double_flip(), 0 );
    send_line( '0, 0 );
    send_packet( DT_FE, 0, 1'b0, '0, 0 );
    finish_test( "test 4 uncorrectable header" );

    send_packet( DT_FS, 0, 1'b0, '0, 0 );
    send_line( '0, 0 );
    send_packet( { 2'( $urandom ), 6'h2A }, 4 * $urandom_range( 12, 1 ), 1'b1, '0, 20 );
    send_packet( { 2'( $urandom ), 6'h08 }, 0, 1'b0, '0, 0 );
    send_packet( { 2'( $urandom ), 6'h12 }, 4 * $urandom_range( 12, 1 ), 1'b1, '0, 20 );
    send_line( '0, 0 );
    send_packet( DT_FE, 0, 1'b0, '0, 0 );
    finish_test( "test 5 other data types" );

    send_frame( 4, 40 );
    finish_test( "test 6 input gaps" );

    $display( "%0d tests run, %0d errors", tests_run, error_cnt );
    if( error_cnt == 0 )
      $display( "PASS: all tests" );
    else
      $display( "FAIL: see errors above" );
    $finish;
  end

endmodule

//--- vlog.f
+incdir+src
src/csi2_rx_pkg.sv
src/csi2_hdr_ecc_dec.sv
src/csi2_pkt_framer.sv
src/csi2_payload_extract.sv
src/csi2_raw10_gearbox.sv
src/csi2_px_unpacker.sv
src/csi2_rx.sv
verification/csi2_rx_tb.sv
